// File: include/link_params.svh
`ifndef LINK_PARAMS_SVH
`define LINK_PARAMS_SVH

// shared buffer RAM, split into two ping-pong halves.
`define LINK_RAM_AW 9

// bytes per buffer half, which is also the largest payload.
`define LINK_HALF_SIZE 256

// cycles from decode to the start of a LINK or TYPE reply.
`define LINK_CONF_DELAY 48

// cycles from decode to the start of a data reply.
`define LINK_DATA_DELAY 80

// idle cycles between two copies of a repeating data reply.
`define LINK_REPEAT_GAP 640

`endif

// File: verilog/link_pkg.sv
`include "link_params.svh"

package link_pkg;

    typedef logic [7:0] byte_t;

    typedef logic [`LINK_RAM_AW-1:0] addr_t;

    // a payload holds 0 to 256 bytes, so nine bits are needed.
    typedef logic [8:0] len_t;

    typedef logic [15:0] delay_t;

    // packet type, carried in the upper nibble of a header byte.
    typedef enum logic [3:0] {
        INIT   = 4'h0,
        DIDX   = 4'h5,
        DPARAM = 4'h6,
        DDIDX  = 4'h7,
        DLINK  = 4'h8,
        DTYPE  = 4'h9,
        DTEMP  = 4'hA,
        DHEAD  = 4'hC,
        DATA0  = 4'hD,
        DATA1  = 4'hE
    } btype_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_PKT,
        ACK,
        DECODE,
        DELAY,
        SEND,
        REPEAT_GAP
    } seq_state_t;

endpackage

// File: verilog/packet_ram.sv
`timescale 1ns/100ps
`include "link_params.svh"

module packet_ram (
    input  logic            clk,
    input  logic            en,
    input  logic            we,
    input  link_pkg::addr_t addr,
    input  link_pkg::byte_t wdata,
    output link_pkg::byte_t rdata
);

    localparam int DEPTH = 2 ** `LINK_RAM_AW;

    link_pkg::byte_t mem [0:DEPTH-1];

    // a write cycle leaves rdata holding the last byte read.
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: verilog/ram_arbiter.sv
`timescale 1ns/100ps

module ram_arbiter (
    input  logic            clk,
    input  logic            rst,
    input  logic            wr_req,
    input  link_pkg::addr_t wr_addr,
    input  link_pkg::byte_t wr_data,
    output logic            wr_gnt,
    input  logic            rd_req,
    input  link_pkg::addr_t rd_addr,
    output logic            rd_gnt,
    output logic            ram_en,
    output logic            ram_we,
    output link_pkg::addr_t ram_addr,
    output link_pkg::byte_t ram_wdata
);

    // high when the sender held the RAM most recently.
    logic last_rd;

    always_comb begin
        wr_gnt = 1'b0;
        rd_gnt = 1'b0;
        if (wr_req && rd_req) begin
            if (last_rd) begin
                wr_gnt = 1'b1;
            end else begin
                rd_gnt = 1'b1;
            end
        end else begin
            wr_gnt = wr_req;
            rd_gnt = rd_req;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_rd <= 1'b0;
        end else if (wr_gnt) begin
            last_rd <= 1'b0;
        end else if (rd_gnt) begin
            last_rd <= 1'b1;
        end
    end

    assign ram_en    = wr_gnt | rd_gnt;
    assign ram_we    = wr_gnt;
    assign ram_addr  = wr_gnt ? wr_addr : rd_addr;
    assign ram_wdata = wr_data;

    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        !(wr_gnt && rd_gnt));

endmodule

// File: verilog/packet_receiver.sv
`timescale 1ns/100ps
`include "link_params.svh"

module packet_receiver (
    input  logic             clk,
    input  logic             rst,
    input  link_pkg::byte_t  rx_data,
    input  logic             rx_valid,
    input  logic             rx_last,
    output logic             rx_ready,
    output logic             wr_req,
    output link_pkg::addr_t  wr_addr,
    output link_pkg::byte_t  wr_data,
    input  logic             wr_gnt,
    output logic             pkt_ready,
    output link_pkg::btype_t pkt_type,
    output link_pkg::addr_t  pkt_base,
    output link_pkg::len_t   pkt_len,
    input  logic             pkt_ack
);

    localparam int OFF_W = `LINK_RAM_AW - 1;

    typedef enum logic [1:0] {
        R_HEADER,
        R_PAYLOAD,
        R_WRITE,
        R_PENDING
    } rx_state_t;

    rx_state_t       state;
    logic            half;
    logic            last_q;
    logic            rx_fire;
    link_pkg::len_t  len;
    link_pkg::byte_t data_q;

    assign rx_fire = rx_valid && rx_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= R_HEADER;
            half  <= 1'b0;
            len   <= '0;
        end else begin
            case (state)
                R_HEADER: begin
                    if (rx_fire) begin
                        len <= '0;
                        if (rx_last) begin
                            half  <= ~half;
                            state <= R_PENDING;
                        end else begin
                            state <= R_PAYLOAD;
                        end
                    end
                end
                R_PAYLOAD: begin
                    if (rx_fire) begin
                        state <= R_WRITE;
                    end
                end
                R_WRITE: begin
                    if (wr_gnt) begin
                        len <= len + 1'b1;
                        if (last_q) begin
                            half  <= ~half;
                            state <= R_PENDING;
                        end else begin
                            state <= R_PAYLOAD;
                        end
                    end
                end
                R_PENDING: begin
                    if (pkt_ack) begin
                        state <= R_HEADER;
                    end
                end
                default: state <= R_HEADER;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == R_HEADER && rx_fire) begin
            pkt_type <= link_pkg::btype_t'(rx_data[7:4]);
        end
        if (state == R_PAYLOAD && rx_fire) begin
            data_q <= rx_data;
            last_q <= rx_last;
        end
    end

    assign rx_ready  = (state == R_HEADER) || (state == R_PAYLOAD);
    assign wr_req    = (state == R_WRITE);
    assign wr_addr   = {half, len[OFF_W-1:0]};
    assign wr_data   = data_q;
    assign pkt_ready = (state == R_PENDING);
    // the half already flipped, so the finished packet sits in the other one.
    assign pkt_base  = {~half, {OFF_W{1'b0}}};
    assign pkt_len   = len;

    a_len_fits: assert property (@(posedge clk) disable iff (rst)
        $rose(pkt_ready) |-> pkt_len <= `LINK_HALF_SIZE);

endmodule

// File: verilog/packet_sender.sv
`timescale 1ns/100ps

module packet_sender (
    input  logic             clk,
    input  logic             rst,
    input  logic             send_start,
    input  link_pkg::btype_t send_type,
    input  link_pkg::addr_t  send_base,
    input  link_pkg::len_t   send_len,
    output logic             send_done,
    output logic             rd_req,
    output link_pkg::addr_t  rd_addr,
    input  logic             rd_gnt,
    input  link_pkg::byte_t  rd_data,
    output link_pkg::byte_t  tx_data,
    output logic             tx_valid,
    output logic             tx_last,
    input  logic             tx_ready
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_TX,
        S_FETCH,
        S_LOAD
    } tx_state_t;

    tx_state_t       state;
    logic            last_q;
    logic            tx_fire;
    link_pkg::len_t  idx;
    link_pkg::len_t  len_q;
    link_pkg::addr_t base_q;
    link_pkg::byte_t data_q;

    assign tx_fire = tx_valid && tx_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            idx       <= '0;
            last_q    <= 1'b0;
            send_done <= 1'b0;
        end else begin
            send_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (send_start) begin
                        idx    <= '0;
                        last_q <= (send_len == '0);
                        state  <= S_TX;
                    end
                end
                S_TX: begin
                    if (tx_fire) begin
                        if (last_q) begin
                            send_done <= 1'b1;
                            state     <= S_IDLE;
                        end else begin
                            state <= S_FETCH;
                        end
                    end
                end
                S_FETCH: begin
                    if (rd_gnt) begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    // rd_data is valid here, one cycle after the grant.
                    idx    <= idx + 1'b1;
                    last_q <= (idx == link_pkg::len_t'(len_q - 1'b1));
                    state  <= S_TX;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && send_start) begin
            data_q <= {send_type, 4'h0};
            base_q <= send_base;
            len_q  <= send_len;
        end else if (state == S_LOAD) begin
            data_q <= rd_data;
        end
    end

    assign rd_req   = (state == S_FETCH);
    assign rd_addr  = base_q + link_pkg::addr_t'(idx);
    assign tx_data  = data_q;
    assign tx_valid = (state == S_TX);
    assign tx_last  = last_q;

    a_tx_hold: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data) && $stable(tx_last)));

endmodule

// File: verilog/link_sequencer.sv
`timescale 1ns/100ps
`include "link_params.svh"

module link_sequencer (
    input  logic             clk,
    input  logic             rst,
    input  logic             pkt_ready,
    input  link_pkg::btype_t pkt_type,
    input  link_pkg::addr_t  pkt_base,
    input  link_pkg::len_t   pkt_len,
    output logic             pkt_ack,
    output logic             send_start,
    output link_pkg::btype_t send_type,
    output link_pkg::addr_t  send_base,
    output link_pkg::len_t   send_len,
    input  logic             send_done,
    output logic             link
);

    link_pkg::seq_state_t state;
    link_pkg::seq_state_t next_state;
    link_pkg::btype_t     type_q;
    link_pkg::delay_t     cnt;
    link_pkg::delay_t     target;
    logic                 repeat_q;
    logic                 delay_hit;
    logic                 gap_hit;
    logic                 counting;

    assign delay_hit = (cnt == target);
    assign gap_hit   = (cnt == link_pkg::delay_t'(`LINK_REPEAT_GAP - 1));
    assign counting  = (state == link_pkg::DELAY) || (state == link_pkg::REPEAT_GAP);

    assign pkt_ack    = (state == link_pkg::ACK);
    assign send_start = ((state == link_pkg::DELAY) && delay_hit) ||
                        ((state == link_pkg::REPEAT_GAP) && !pkt_ready && gap_hit);

    always_comb begin
        next_state = state;
        case (state)
            link_pkg::IDLE: next_state = link_pkg::WAIT_PKT;
            link_pkg::WAIT_PKT: begin
                if (pkt_ready) next_state = link_pkg::ACK;
            end
            link_pkg::ACK: next_state = link_pkg::DECODE;
            link_pkg::DECODE: begin
                case (type_q)
                    link_pkg::DLINK, link_pkg::DTYPE, link_pkg::DTEMP,
                    link_pkg::DATA0, link_pkg::DATA1: next_state = link_pkg::DELAY;
                    default: next_state = link_pkg::WAIT_PKT;
                endcase
            end
            link_pkg::DELAY: begin
                if (delay_hit) next_state = link_pkg::SEND;
            end
            link_pkg::SEND: begin
                if (send_done) begin
                    next_state = repeat_q ? link_pkg::REPEAT_GAP : link_pkg::WAIT_PKT;
                end
            end
            // a new packet ends the repeat before the gap runs out.
            link_pkg::REPEAT_GAP: begin
                if (pkt_ready) begin
                    next_state = link_pkg::ACK;
                end else if (gap_hit) begin
                    next_state = link_pkg::SEND;
                end
            end
            default: next_state = link_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= link_pkg::IDLE;
            cnt       <= '0;
            target    <= '0;
            repeat_q  <= 1'b0;
            link      <= 1'b0;
            send_type <= link_pkg::INIT;
        end else begin
            state <= next_state;
            if (counting && next_state == state) begin
                cnt <= cnt + 1'b1;
            end else begin
                cnt <= '0;
            end
            if (state == link_pkg::DECODE) begin
                repeat_q <= 1'b0;
                target   <= link_pkg::delay_t'(`LINK_CONF_DELAY);
                case (type_q)
                    link_pkg::DLINK: begin
                        link      <= 1'b1;
                        send_type <= link_pkg::DIDX;
                    end
                    link_pkg::DTYPE: send_type <= link_pkg::DPARAM;
                    link_pkg::DTEMP, link_pkg::DATA0, link_pkg::DATA1: begin
                        send_type <= link_pkg::DDIDX;
                        target    <= link_pkg::delay_t'(`LINK_DATA_DELAY);
                        repeat_q  <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // the packet fields are still stable in the ack cycle.
    always_ff @(posedge clk) begin
        if (state == link_pkg::ACK) begin
            type_q    <= pkt_type;
            send_base <= pkt_base;
            send_len  <= pkt_len;
        end
    end

    a_no_start_in_send: assert property (@(posedge clk) disable iff (rst)
        (state == link_pkg::SEND) |-> !send_start);

    a_done_in_send: assert property (@(posedge clk) disable iff (rst)
        send_done |-> (state == link_pkg::SEND));

endmodule

// File: verilog/link_top.sv
`timescale 1ns/100ps

module link_top (
    input  logic            clk,
    input  logic            rst,
    input  link_pkg::byte_t rx_data,
    input  logic            rx_valid,
    input  logic            rx_last,
    output logic            rx_ready,
    output link_pkg::byte_t tx_data,
    output logic            tx_valid,
    output logic            tx_last,
    input  logic            tx_ready,
    output logic            link
);

    logic             wr_req;
    logic             wr_gnt;
    link_pkg::addr_t  wr_addr;
    link_pkg::byte_t  wr_data;
    logic             rd_req;
    logic             rd_gnt;
    link_pkg::addr_t  rd_addr;
    link_pkg::byte_t  rd_data;
    logic             ram_en;
    logic             ram_we;
    link_pkg::addr_t  ram_addr;
    link_pkg::byte_t  ram_wdata;
    logic             pkt_ready;
    logic             pkt_ack;
    link_pkg::btype_t pkt_type;
    link_pkg::addr_t  pkt_base;
    link_pkg::len_t   pkt_len;
    logic             send_start;
    logic             send_done;
    link_pkg::btype_t send_type;
    link_pkg::addr_t  send_base;
    link_pkg::len_t   send_len;

    packet_receiver u_receiver (
        .clk, .rst, .rx_data, .rx_valid, .rx_last, .rx_ready,
        .wr_req, .wr_addr, .wr_data, .wr_gnt,
        .pkt_ready, .pkt_type, .pkt_base, .pkt_len, .pkt_ack
    );

    packet_sender u_sender (
        .clk, .rst, .send_start, .send_type, .send_base, .send_len, .send_done,
        .rd_req, .rd_addr, .rd_gnt, .rd_data,
        .tx_data, .tx_valid, .tx_last, .tx_ready
    );

    link_sequencer u_sequencer (
        .clk, .rst, .pkt_ready, .pkt_type, .pkt_base, .pkt_len, .pkt_ack,
        .send_start, .send_type, .send_base, .send_len, .send_done, .link
    );

    ram_arbiter u_arbiter (
        .clk, .rst, .wr_req, .wr_addr, .wr_data, .wr_gnt,
        .rd_req, .rd_addr, .rd_gnt,
        .ram_en, .ram_we, .ram_addr, .ram_wdata
    );

    packet_ram u_ram (
        .clk,
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (rd_data)
    );

endmodule

// File: dv/link_tb.sv
`timescale 1ns/100ps
`include "link_params.svh"

module link_tb;

    localparam int MAX_BYTES       = 1024;
    localparam int REPLY_TIMEOUT   = `LINK_REPEAT_GAP + `LINK_DATA_DELAY
                                     + 16 * (`LINK_HALF_SIZE + 2);
    localparam int QUIET_CYCLES    = `LINK_REPEAT_GAP + `LINK_DATA_DELAY + 64;
    // ten replies, one repeat gap, the quiet wait of test 5, and every byte both ways.
    localparam int WATCHDOG_CYCLES = 10 * (`LINK_DATA_DELAY + 32) + 2 * QUIET_CYCLES
                                     + 16 * MAX_BYTES + 2000;

    logic            clk;
    logic            rst;
    link_pkg::byte_t rx_data;
    logic            rx_valid;
    logic            rx_last;
    logic            rx_ready;
    link_pkg::byte_t tx_data;
    logic            tx_valid;
    logic            tx_last;
    logic            tx_ready;
    logic            link;

    logic [31:0] data_lfsr;
    logic [31:0] stall_lfsr;
    logic        stall_en;
    logic        link_allowed;
    logic [7:0]  payload [$];
    logic [8:0]  exp_q [$];
    logic        exp_avail;
    logic [7:0]  exp_data;
    logic        exp_last;
    int          replies_seen;
    int          errors;
    int          err_mark;
    int          tests_run;
    int          tests_failed;

    link_top UUT (
        .clk, .rst, .rx_data, .rx_valid, .rx_last, .rx_ready,
        .tx_data, .tx_valid, .tx_last, .tx_ready, .link
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        galois_step = (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // reply type for each packet type, from the decode rules.
    function automatic logic [3:0] reply_type(input logic [3:0] ptype);
        case (ptype)
            link_pkg::DLINK: reply_type = link_pkg::DIDX;
            link_pkg::DTYPE: reply_type = link_pkg::DPARAM;
            default:         reply_type = link_pkg::DDIDX;
        endcase
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            data_lfsr = galois_step(data_lfsr);
            v = {v[30:0], data_lfsr[0]};
        end
    endtask

    task automatic make_payload(input int n);
        logic [31:0] v;
        int          i;
        payload.delete();
        for (i = 0; i < n; i++) begin
            take_bits(8, v);
            payload.push_back(v[7:0]);
        end
    endtask

    task automatic refresh_head();
        if (exp_q.size() != 0) begin
            exp_avail = 1'b1;
            exp_data  = exp_q[0][7:0];
            exp_last  = exp_q[0][8];
        end else begin
            exp_avail = 1'b0;
            exp_data  = 8'h00;
            exp_last  = 1'b0;
        end
    endtask

    task automatic expect_reply(input logic [3:0] rtype);
        int i;
        exp_q.push_back({payload.size() == 0, rtype, 4'h0});
        for (i = 0; i < payload.size(); i++) begin
            exp_q.push_back({i == payload.size() - 1, payload[i]});
        end
        refresh_head();
    endtask

    // called on a falling edge with a byte driven; returns on the next falling
    // edge after the byte has transferred.
    task automatic wait_accept();
        while (!rx_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic send_packet(input logic [3:0] ptype);
        logic [31:0] v;
        int          i;
        take_bits(4, v);
        @(negedge clk);
        rx_valid = 1'b1;
        rx_data  = {ptype, v[3:0]};
        rx_last  = (payload.size() == 0);
        wait_accept();
        for (i = 0; i < payload.size(); i++) begin
            rx_data = payload[i];
            rx_last = (i == payload.size() - 1);
            wait_accept();
        end
        rx_valid = 1'b0;
        rx_last  = 1'b0;
    endtask

    task automatic wait_replies(input int target);
        int cycles;
        cycles = 0;
        while (replies_seen < target && cycles < REPLY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (replies_seen < target) begin
            $display("timed out waiting for reply %0d after %0d cycles", target, cycles);
            errors++;
        end
    endtask

    task automatic echo_packet(input logic [3:0] ptype, input int n);
        int target;
        make_payload(n);
        if (ptype == link_pkg::DLINK) begin
            link_allowed = 1'b1;
        end
        expect_reply(reply_type(ptype));
        target = replies_seen + 1;
        send_packet(ptype);
        wait_replies(target);
    endtask

    task automatic finish_test(input int num, input string name);
        int test_errors;
        assert (exp_q.size() == 0) else begin
            $display("%0d expected reply bytes never appeared on tx", exp_q.size());
            errors++;
        end
        exp_q.delete();
        refresh_head();
        test_errors = errors - err_mark;
        err_mark    = errors;
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name, test_errors);
        end
    endtask

    // tx_ready is high about three cycles in four while stalls are on.
    always @(negedge clk) begin
        if (stall_en) begin
            stall_lfsr = galois_step(stall_lfsr);
            tx_ready   = stall_lfsr[0];
            stall_lfsr = galois_step(stall_lfsr);
            tx_ready   = tx_ready | stall_lfsr[0];
        end else begin
            tx_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst && tx_valid && tx_ready) begin
            if (exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            if (tx_last) begin
                replies_seen++;
            end
            refresh_head();
        end
    end

    a_reset_state: assert property (@(posedge clk)
        $fell(rst) |-> (rx_ready && !tx_valid && !link && !UUT.pkt_ready && !UUT.send_start))
        else begin
            $display("[FAIL] after reset: rx_ready=0x%h tx_valid=0x%h link=0x%h",
                     $sampled(rx_ready), $sampled(tx_valid), $sampled(link));
            errors++;
        end

    a_tx_expected: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && tx_ready) |-> exp_avail)
        else begin
            $display("tx byte 0x%h was sent while no reply was expected", $sampled(tx_data));
            errors++;
        end

    a_tx_data: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && tx_ready && exp_avail) |-> (tx_data == exp_data))
        else begin
            $display("[FAIL] tx_data: got 0x%h, expected 0x%h",
                     $sampled(tx_data), $sampled(exp_data));
            errors++;
        end

    a_tx_last: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && tx_ready && exp_avail) |-> (tx_last == exp_last))
        else begin
            $display("[FAIL] tx_last: got 0x%h, expected 0x%h",
                     $sampled(tx_last), $sampled(exp_last));
            errors++;
        end

    a_rx_blocked: assert property (@(posedge clk) disable iff (rst)
        UUT.pkt_ready |-> !rx_ready)
        else begin
            $display("rx_ready was high while a finished packet was pending");
            errors++;
        end

    a_link_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(link) |-> link_allowed)
        else begin
            $display("link rose before any DLINK packet was sent");
            errors++;
        end

    a_link_hold: assert property (@(posedge clk) disable iff (rst) !$fell(link))
        else begin
            $display("link cleared without a reset");
            errors++;
        end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [31:0] r;
        int          target;
        int          k;
        clk          = 1'b0;
        rst          = 1'b1;
        rx_data      = 8'h00;
        rx_valid     = 1'b0;
        rx_last      = 1'b0;
        tx_ready     = 1'b1;
        data_lfsr    = 32'he6d9;
        stall_lfsr   = 32'he6d9;
        stall_en     = 1'b0;
        link_allowed = 1'b0;
        replies_seen = 0;
        errors       = 0;
        err_mark     = 0;
        tests_run    = 0;
        tests_failed = 0;
        refresh_head();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);
        finish_test(1, "reset state");

        take_bits(5, r);
        echo_packet(link_pkg::DLINK, r[4:0] + 1);
        assert (link === 1'b1) else begin
            $display("[FAIL] link: got 0x%h, expected 0x1", link);
            errors++;
        end
        finish_test(2, "dlink reply");

        take_bits(5, r);
        echo_packet(link_pkg::DTYPE, r[4:0] + 1);
        echo_packet(link_pkg::DTYPE, 0);
        finish_test(3, "dtype replies");

        // two copies of the DTEMP reply, then DATA0 lands in the gap.
        take_bits(5, r);
        echo_packet(link_pkg::DTEMP, r[4:0] + 1);
        target = replies_seen + 1;
        expect_reply(link_pkg::DDIDX);
        wait_replies(target);
        take_bits(6, r);
        echo_packet(link_pkg::DATA0, r[5:0] + 1);
        finish_test(4, "repeat and interrupt");

        // this also ends the DATA0 repeat before its gap runs out.
        // link was set by the DLINK packet of test 2 and only a reset clears it.
        take_bits(5, r);
        make_payload(r[4:0]);
        send_packet(link_pkg::DHEAD);
        repeat (QUIET_CYCLES) @(negedge clk);
        assert (link === 1'b1) else begin
            $display("[FAIL] link: got 0x%h, expected 0x1", link);
            errors++;
        end
        finish_test(5, "ignored type");

        stall_en = 1'b1;
        for (k = 0; k < 4; k++) begin
            take_bits(6, r);
            if (k == 3) begin
                echo_packet(link_pkg::DTYPE, `LINK_HALF_SIZE);
            end else if (k % 2 == 0) begin
                echo_packet(link_pkg::DLINK, r[5:0]);
            end else begin
                echo_packet(link_pkg::DTYPE, r[5:0]);
            end
        end
        stall_en = 1'b0;
        finish_test(6, "tx stalls");

        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+include
verilog/link_pkg.sv
verilog/packet_ram.sv
verilog/ram_arbiter.sv
verilog/packet_receiver.sv
verilog/packet_sender.sv
verilog/link_sequencer.sv
verilog/link_top.sv
dv/link_tb.sv

// File: Bender.yml
package:
  name: link_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/link_pkg.sv
      - verilog/packet_ram.sv
      - verilog/ram_arbiter.sv
      - verilog/packet_receiver.sv
      - verilog/packet_sender.sv
      - verilog/link_sequencer.sv
      - verilog/link_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/link_tb.sv
